// File: hdl/armExec_defines.svh
`ifndef ARM_EXEC_DEFINES_SVH
`define ARM_EXEC_DEFINES_SVH

// Datapath sizing for the execute stage

`define DATA_W 32 // Operand and result width

`define REG_W 4 // Register index, r0..r15

`endif

// File: hdl/armExecPkg.sv
`include "armExec_defines.svh"

package armExecPkg;

    // ARM data-processing opcode, instruction bits 24..21
    typedef enum logic [3:0] {
        dpAnd = 4'b0000,
        dpEor = 4'b0001,
        dpSub = 4'b0010,
        dpRsb = 4'b0011,
        dpAdd = 4'b0100,
        dpAdc = 4'b0101,
        dpSbc = 4'b0110,
        dpRsc = 4'b0111,
        dpTst = 4'b1000,
        dpTeq = 4'b1001,
        dpCmp = 4'b1010,
        dpCmn = 4'b1011,
        dpOrr = 4'b1100,
        dpMov = 4'b1101,
        dpBic = 4'b1110,
        dpMvn = 4'b1111
    } dpOpcode_e;

    // ALU result select, codes 6 and 7 unused
    typedef enum logic [2:0] {
        opAnd   = 3'd0,
        opXor   = 3'd1,
        opSum   = 3'd2,
        opOr    = 3'd3,
        opPassB = 3'd4,
        opBx    = 3'd5
    } aluOp_e;

    typedef struct packed {
        logic updC;  // C from adder carry-out
        logic keepV; // Set for ADD only
        logic updV;  // V from overflow
    } cvUpdate_t;

    typedef struct packed {
        logic               aluOp;     // Data-processing instruction
        dpOpcode_e          opcode;
        logic               setFlags;  // S bit
        logic               bxInstr;
        logic               regToCpsr; // Result goes to CPSR, not Rd
        logic [`REG_W-1:0]  rd;
        logic [`DATA_W-1:0] srcA;
        logic [`DATA_W-1:0] srcB;
    } execReq_t;

    typedef struct packed {
        aluOp_e    operation;
        logic      invertB;
        logic      reverseInputs; // Swap A and B, RSB/RSC
        logic      carryIn;
        cvUpdate_t cvUpdate;
        logic      doNotWriteReg;
    } aluCtrl_t;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } nzcv_t;

    typedef struct packed {
        logic [`DATA_W-1:0] value;
        logic [`REG_W-1:0]  rd;
        logic               writeReg;
    } execResult_t;

endpackage

// File: hdl/execInputStage.sv
module execInputStage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issue,
    input  armExecPkg::execReq_t req,
    output logic                 stageValid,
    output armExecPkg::execReq_t stageReq
);

    // Decode to execute pipeline register

    always_ff @(posedge clk) begin
        if (rst) begin
            stageValid <= 1'b0;
        end else begin
            stageValid <= issue; // One-cycle strobe, no stall
        end
    end

    // Payload only loads on issue, so operands hold steady between
    // instructions and the ALU inputs don't toggle on idle cycles
    always_ff @(posedge clk) begin
        if (issue) begin
            stageReq <= req;
        end
    end

endmodule

// File: hdl/aluDecoder.sv
module aluDecoder (
    input  logic                 [1:0] prevCV,
    input  armExecPkg::execReq_t       stageReq,
    output armExecPkg::aluCtrl_t       ctrl
);
    import armExecPkg::*;

    logic      dp;  // Data-processing request
    dpOpcode_e opc;

    assign dp  = stageReq.aluOp;
    assign opc = stageReq.opcode;

    always_comb begin
        ctrl = '0;
        ctrl.operation = opSum; // Non-DP requests just add

        // Operand routing
        ctrl.reverseInputs = dp && (opc inside {dpRsb, dpRsc});
        ctrl.invertB       = dp && (opc inside {dpSub, dpRsb, dpSbc, dpRsc,
                                                dpCmp, dpMvn, dpBic});

        // Carry-in, C acts as not-borrow for SBC/RSC
        if (dp) begin
            case (opc)
                dpSub, dpRsb, dpCmp: ctrl.carryIn = 1'b1; // A + ~B + 1
                dpAdc, dpSbc, dpRsc: ctrl.carryIn = prevCV[1]; // Previous C
                default:             ctrl.carryIn = 1'b0;
            endcase
        end

        // Result select
        if (!dp) begin
            ctrl.operation = stageReq.bxInstr ? opBx : opSum;
        end else begin
            case (opc)
                dpAnd, dpTst, dpBic: ctrl.operation = opAnd; // BIC via inverted B
                dpEor, dpTeq:        ctrl.operation = opXor;
                dpOrr:               ctrl.operation = opOr;
                dpMov, dpMvn:        ctrl.operation = opPassB;
                default:             ctrl.operation = opSum; // Arithmetic and CMP/CMN
            endcase
        end

        // Flag update mask, logic ops leave C and V alone
        if (dp) begin
            case (opc)
                dpSub, dpRsb, dpSbc, dpRsc, dpCmp: ctrl.cvUpdate = 3'b101;
                dpAdc, dpCmn:                      ctrl.cvUpdate = 3'b101; // Add with V too
                dpAdd:                             ctrl.cvUpdate = 3'b110; // keepV path
                default:                           ctrl.cvUpdate = 3'b000;
            endcase
        end

        // Compares and CPSR moves never touch Rd
        ctrl.doNotWriteReg = (dp && (opc inside {dpTst, dpTeq, dpCmp, dpCmn}))
                           || stageReq.regToCpsr;
    end

endmodule

// File: hdl/aluCore.sv
`include "armExec_defines.svh"

module aluCore (
    input  logic                 [`DATA_W-1:0] srcA,
    input  logic                 [`DATA_W-1:0] srcB,
    input  armExecPkg::aluCtrl_t               ctrl,
    output logic                 [`DATA_W-1:0] aluValue,
    output logic                               aluCarry,
    output logic                               aluOverflow
);
    import armExecPkg::*;

    localparam int MSB = `DATA_W - 1;

    logic [`DATA_W-1:0] opA;    // After swap
    logic [`DATA_W-1:0] opBRaw; // After swap, before inversion
    logic [`DATA_W-1:0] opB;
    logic [`DATA_W:0]   sum;    // Extra bit holds carry-out

    assign opA    = ctrl.reverseInputs ? srcB : srcA;
    assign opBRaw = ctrl.reverseInputs ? srcA : srcB;
    assign opB    = ctrl.invertB ? ~opBRaw : opBRaw;

    // Subtraction is A + ~B + 1, so carry-out is not-borrow
    assign sum = {1'b0, opA} + {1'b0, opB} + {{`DATA_W{1'b0}}, ctrl.carryIn};

    assign aluCarry = sum[`DATA_W];

    // Same-sign inputs, different-sign result
    assign aluOverflow = (opA[MSB] == opB[MSB]) && (sum[MSB] != opA[MSB]);

    always_comb begin
        case (ctrl.operation)
            opAnd:   aluValue = opA & opB;
            opXor:   aluValue = opA ^ opB;
            opOr:    aluValue = opA | opB;
            opPassB: aluValue = opB; // MOV, or MVN with invertB
            opBx:    aluValue = {srcB[MSB:1], 1'b0}; // Target, Thumb bit cleared
            default: aluValue = sum[MSB:0];
        endcase
    end

endmodule

// File: hdl/execOutputStage.sv
`include "armExec_defines.svh"

module execOutputStage (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  stageValid,
    input  logic                                  setFlags,
    input  armExecPkg::aluCtrl_t                  ctrl,
    input  logic                    [`REG_W-1:0]  rd,
    input  logic                    [`DATA_W-1:0] aluValue,
    input  logic                                  aluCarry,
    input  logic                                  aluOverflow,
    output logic                                  resultValid,
    output armExecPkg::execResult_t               result,
    output armExecPkg::nzcv_t                     flags
);
    import armExecPkg::*;

    nzcv_t nextFlags;

    // Selective NZCV update, S bit gates everything
    always_comb begin
        nextFlags = flags;
        if (setFlags) begin
            nextFlags.n = aluValue[`DATA_W-1];
            nextFlags.z = (aluValue == '0);
            if (ctrl.cvUpdate.updC) begin
                nextFlags.c = aluCarry;
            end
            if (ctrl.cvUpdate.updV || ctrl.cvUpdate.keepV) begin
                nextFlags.v = aluOverflow;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resultValid <= 1'b0;
            flags       <= '0;
        end else begin
            resultValid <= stageValid; // Pulse per instruction
            if (stageValid) begin
                flags <= nextFlags; // Seen by the next instruction in execute
            end
        end
    end

    always_ff @(posedge clk) begin
        if (stageValid) begin
            result.value    <= aluValue;
            result.rd       <= rd;
            result.writeReg <= !ctrl.doNotWriteReg;
        end
    end

    // C and V only ever come from the adder
    cvFromAdder: assert property (@(posedge clk) disable iff (rst)
        stageValid && (ctrl.cvUpdate != '0) |-> ctrl.operation == opSum)
        else $error("execOutputStage: C/V update on a non-adder operation");

    // A valid instruction never carries unknowns into Rd or NZCV
    knownWhenValid: assert property (@(posedge clk) disable iff (rst)
        stageValid |-> !$isunknown({ctrl, rd, aluValue, aluCarry, aluOverflow, setFlags}))
        else $error("execOutputStage: unknown value on a valid instruction");

endmodule

// File: hdl/armExecute.sv
`include "armExec_defines.svh"

module armExecute (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    issue,
    input  armExecPkg::execReq_t    req,
    output logic                    resultValid,
    output armExecPkg::execResult_t result,
    output armExecPkg::nzcv_t       flags
);
    import armExecPkg::*;

    logic               stageValid;
    execReq_t           stageReq;
    aluCtrl_t           ctrl;
    logic [`DATA_W-1:0] aluValue;
    logic               aluCarry;
    logic               aluOverflow;

    execInputStage inStage (
        .clk        (clk),
        .rst        (rst),
        .issue      (issue),
        .req        (req),
        .stageValid (stageValid),
        .stageReq   (stageReq)
    );

    aluDecoder decoder (
        .prevCV   ({flags.c, flags.v}), // Flag feedback, C in bit 1
        .stageReq (stageReq),
        .ctrl     (ctrl)
    );

    aluCore alu (
        .srcA        (stageReq.srcA),
        .srcB        (stageReq.srcB),
        .ctrl        (ctrl),
        .aluValue    (aluValue),
        .aluCarry    (aluCarry),
        .aluOverflow (aluOverflow)
    );

    execOutputStage outStage (
        .clk         (clk),
        .rst         (rst),
        .stageValid  (stageValid),
        .setFlags    (stageReq.setFlags && stageReq.aluOp), // S only on DP ops
        .ctrl        (ctrl),
        .rd          (stageReq.rd),
        .aluValue    (aluValue),
        .aluCarry    (aluCarry),
        .aluOverflow (aluOverflow),
        .resultValid (resultValid),
        .result      (result),
        .flags       (flags)
    );

endmodule

// File: sim/armExecute_tb.sv
`include "armExec_defines.svh"

module armExecute_tb;
    import armExecPkg::*;

    localparam int          RESET_CYCLES = 5;
    localparam int unsigned SEED         = 32'hd51e1dd4;

    typedef struct {
        string              name;
        logic               dp;     // aluOp bit
        dpOpcode_e          opc;
        logic               s;
        logic               bx;
        logic               toCpsr;
        logic [`DATA_W-1:0] a;
        logic [`DATA_W-1:0] b;
        logic               gap;    // Idle cycle before issue
    } testRow_t;

    typedef struct {
        string       name;
        execResult_t result;
        nzcv_t       flags;
        int          dueCycle; // Cycle count at the result
    } pending_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        issue;
    execReq_t    req;
    logic        resultValid;
    execResult_t result;
    nzcv_t       flags;

    testRow_t    tests[$];
    pending_t    pendingQ[$];
    nzcv_t       modelFlags;   // Reference copy of NZCV
    int          cycleCount = 0;
    int          cycleLimit = RESET_CYCLES + 20;
    int          issueCount = 0;
    int          resultCount = 0;
    int unsigned seedDummy;

    armExecute UUT (
        .clk         (clk),
        .rst         (rst),
        .issue       (issue),
        .req         (req),
        .resultValid (resultValid),
        .result      (result),
        .flags       (flags)
    );

    always #5 clk = ~clk;

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic checkResult(input string name, input execResult_t exp, input execResult_t act);
        if (act !== exp) begin
            $display("error: %s result expected %h actual %h", name, exp, act);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic checkFlags(input string name, input nzcv_t exp, input nzcv_t act);
        if (act !== exp) begin
            $display("error: %s flags expected %b actual %b", name, exp, act);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic addRow(input string name, input logic dp, input dpOpcode_e opc,
                          input logic s, input logic bx, input logic toCpsr,
                          input logic [`DATA_W-1:0] a, input logic [`DATA_W-1:0] b,
                          input logic gap);
        testRow_t row;
        row = '{name, dp, opc, s, bx, toCpsr, a, b, gap};
        tests.push_back(row);
    endtask

    // ARM data-processing semantics, flags only on S with a DP opcode
    function automatic void predict(input testRow_t t, inout nzcv_t f,
                                    output logic [`DATA_W-1:0] value);
        logic [`DATA_W:0]   wide;
        logic [`DATA_W-1:0] x;
        logic [`DATA_W-1:0] y;
        logic               cin;
        logic               arith;
        x     = t.a;
        y     = t.b;
        cin   = 1'b0;
        arith = 1'b0;
        wide  = '0;
        value = '0;
        if (!t.dp) begin
            value = t.bx ? {t.b[`DATA_W-1:1], 1'b0} : t.a + t.b; // BX target or plain add
        end else begin
            case (t.opc)
                dpAnd, dpTst: value = t.a & t.b;
                dpEor, dpTeq: value = t.a ^ t.b;
                dpOrr:        value = t.a | t.b;
                dpBic:        value = t.a & ~t.b;
                dpMov:        value = t.b;
                dpMvn:        value = ~t.b;
                dpAdd, dpCmn: arith = 1'b1;
                dpAdc: begin
                    arith = 1'b1;
                    cin   = f.c;
                end
                dpSub, dpCmp: begin
                    arith = 1'b1;
                    y     = ~t.b;
                    cin   = 1'b1;
                end
                dpSbc: begin
                    arith = 1'b1;
                    y     = ~t.b;
                    cin   = f.c;
                end
                dpRsb: begin
                    arith = 1'b1;
                    x     = t.b;
                    y     = ~t.a;
                    cin   = 1'b1;
                end
                dpRsc: begin
                    arith = 1'b1;
                    x     = t.b;
                    y     = ~t.a;
                    cin   = f.c;
                end
                default:      value = '0;
            endcase
        end
        if (arith) begin
            wide  = {1'b0, x} + {1'b0, y} + cin;
            value = wide[`DATA_W-1:0];
        end
        if (t.dp && t.s) begin
            f.n = value[`DATA_W-1];
            f.z = (value == '0);
            if (arith) begin
                f.c = wide[`DATA_W]; // Carry is not-borrow on subtract
                f.v = (x[`DATA_W-1] == y[`DATA_W-1]) && (value[`DATA_W-1] != x[`DATA_W-1]);
            end
        end
    endfunction

    task automatic buildTable();
        addRow("adds c v set",  1, dpAdd, 1, 0, 0, 32'h8000_0000, 32'h8000_0000, 0);
        addRow("movs zero",     1, dpMov, 1, 0, 0, 32'h1234_5678, 32'h0000_0000, 0);
        addRow("mvns neg",      1, dpMvn, 1, 0, 0, 32'h0000_0000, 32'h0000_0000, 0);
        addRow("and rand",      1, dpAnd, 0, 0, 0, $urandom(), $urandom(), 0);
        addRow("ands zero",     1, dpAnd, 1, 0, 0, 32'hf0f0_f0f0, 32'h0f0f_0f0f, 0);
        addRow("eors rand",     1, dpEor, 1, 0, 0, $urandom(), $urandom(), 0);
        addRow("orrs rand",     1, dpOrr, 1, 0, 0, $urandom(), $urandom(), 1);
        addRow("bics rand",     1, dpBic, 1, 0, 0, $urandom(), $urandom(), 0);
        addRow("adds wrap",     1, dpAdd, 1, 0, 0, 32'hffff_ffff, 32'h0000_0001, 1);
        addRow("adds ovf",      1, dpAdd, 1, 0, 0, 32'h7fff_ffff, 32'h0000_0001, 0);
        addRow("subs borrow",   1, dpSub, 1, 0, 0, 32'h0000_0005, 32'h0000_0007, 0);
        addRow("subs ovf",      1, dpSub, 1, 0, 0, 32'h8000_0000, 32'h0000_0001, 0);
        addRow("rsbs",          1, dpRsb, 1, 0, 0, 32'h0000_0003, 32'h0000_000a, 0);
        addRow("adds carry",    1, dpAdd, 1, 0, 0, 32'hffff_ffff, 32'hffff_ffff, 0);
        addRow("adcs c1",       1, dpAdc, 1, 0, 0, 32'h0000_0001, 32'h0000_0002, 0);
        addRow("adcs c0",       1, dpAdc, 1, 0, 0, 32'hffff_ffff, 32'h0000_0001, 0);
        addRow("sbcs c1",       1, dpSbc, 1, 0, 0, 32'h0000_000a, 32'h0000_0003, 0);
        addRow("subs to c0",    1, dpSub, 1, 0, 0, 32'h0000_0000, 32'h0000_0001, 0);
        addRow("sbcs c0",       1, dpSbc, 1, 0, 0, 32'h0000_000a, 32'h0000_0003, 0);
        addRow("rscs chain",    1, dpRsc, 1, 0, 0, 32'h0000_0002, 32'h0000_0009, 0);
        addRow("add no s",      1, dpAdd, 0, 0, 0, 32'hffff_ffff, 32'h0000_0002, 0);
        addRow("cmp equal",     1, dpCmp, 1, 0, 0, 32'h0000_0005, 32'h0000_0005, 1);
        addRow("cmn ovf",       1, dpCmn, 1, 0, 0, 32'h8000_0000, 32'h8000_0000, 0);
        addRow("tst rand",      1, dpTst, 1, 0, 0, $urandom(), $urandom(), 0);
        addRow("teq equal",     1, dpTeq, 1, 0, 0, 32'hcafe_f00d, 32'hcafe_f00d, 0);
        addRow("mov to cpsr",   1, dpMov, 0, 0, 1, 32'h0000_0000, 32'hf000_0000, 0);
        addRow("bx thumb",      0, dpAnd, 1, 1, 0, 32'h0000_0000, 32'h0000_8001, 1);
        addRow("non dp add",    0, dpAnd, 1, 0, 0, 32'h0000_1000, 32'h0000_0234, 0);
    endtask

    // Run limit, result checks
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout after %0d cycles, %0d of %0d results seen",
                     cycleCount, resultCount, issueCount);
            $display("Testbench failed");
            $fatal(1);
        end
    end

    always @(negedge clk) begin
        pending_t ent;
        if (!rst && resultValid) begin
            if (pendingQ.size() == 0) begin
                abortRun("A result came out with no instruction in flight");
            end else begin
                ent = pendingQ.pop_front();
                if (cycleCount != ent.dueCycle) begin
                    abortRun($sformatf("%s came out at cycle %0d instead of %0d",
                                       ent.name, cycleCount, ent.dueCycle));
                end else begin
                    checkResult(ent.name, ent.result, result);
                    checkFlags(ent.name, ent.flags, flags);
                    resultCount++;
                end
            end
        end
    end

    initial begin
        testRow_t           row;
        pending_t           ent;
        logic [`DATA_W-1:0] value;
        int                 gaps;
        seedDummy  = $urandom(SEED); // One seed for the whole run
        rst        = 1'b1;
        issue      = 1'b0;
        req        = '0;
        modelFlags = '0;
        buildTable();
        gaps = 0;
        foreach (tests[i]) begin
            if (tests[i].gap) gaps++;
        end
        cycleLimit = RESET_CYCLES + tests.size() + gaps + 20;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
        @(negedge clk);
        if (resultValid !== 1'b0) begin
            abortRun("resultValid is high right after reset");
        end else begin
            checkFlags("after reset", '0, flags);
        end
        foreach (tests[i]) begin
            row = tests[i];
            if (row.gap) begin
                @(posedge clk);
                #1 issue = 1'b0; // Idle cycle
            end
            @(posedge clk);
            #1;
            issue         = 1'b1;
            req.aluOp     = row.dp;
            req.opcode    = row.opc;
            req.setFlags  = row.s;
            req.bxInstr   = row.bx;
            req.regToCpsr = row.toCpsr;
            req.rd        = i[`REG_W-1:0];
            req.srcA      = row.a;
            req.srcB      = row.b;
            predict(row, modelFlags, value);
            ent.name            = row.name;
            ent.result.value    = value;
            ent.result.rd       = i[`REG_W-1:0];
            ent.result.writeReg = !(row.toCpsr ||
                                    (row.dp && row.opc inside {dpTst, dpTeq, dpCmp, dpCmn}));
            ent.flags           = modelFlags;
            ent.dueCycle        = cycleCount + 2; // Two-cycle latency
            pendingQ.push_back(ent);
            issueCount++;
        end
        @(posedge clk);
        #1 issue = 1'b0;
        wait (resultCount == issueCount);
        repeat (4) @(posedge clk); // Catch stray extra results
        if (resultCount != issueCount || pendingQ.size() != 0) begin
            $display("Issued %0d instructions but saw %0d results", issueCount, resultCount);
            $display("Testbench failed");
            $fatal(1);
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

// File: project.f
+incdir+hdl
hdl/armExecPkg.sv
hdl/execInputStage.sv
hdl/aluDecoder.sv
hdl/aluCore.sv
hdl/execOutputStage.sv
hdl/armExecute.sv
sim/armExecute_tb.sv

// File: Bender.yml
package:
  name: arm_execute

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/armExecPkg.sv
      - hdl/execInputStage.sv
      - hdl/aluDecoder.sv
      - hdl/aluCore.sv
      - hdl/execOutputStage.sv
      - hdl/armExecute.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - sim/armExecute_tb.sv
